//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module spmm_tb -f filelist.f -o spmm_sim
	./obj_dir/spmm_sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
hdl/spmm_pkg.sv
hdl/spmm_nz_if.sv
hdl/spmm_row_decode.sv
hdl/spmm_weight_mem.sv
hdl/spmm_pe.sv
hdl/spmm_row_result.sv
hdl/spmm_top.sv
tests/spmm_chk.sv
tests/spmm_tb.sv

//--- hdl/spmm_nz_if.sv
`timescale 1ns/100ps
`default_nettype none

// One decoded nonzero beat with the header fields of its row
interface spmm_nz_if;

  logic                 vld;
  spmm_pkg::col_idx_t   col_idx;
  spmm_pkg::data_t      val;
  logic                 first;
  logic                 last;
  spmm_pkg::num_node_t  num_node;
  logic                 src_flag;

  modport decode (
    output vld, col_idx, val, first, last, num_node, src_flag
  );

  modport pe (
    input vld, col_idx, val, first, last, num_node, src_flag
  );

endinterface

`default_nettype wire

//--- hdl/spmm_pe.sv
`timescale 1ns/100ps
`default_nettype none

module spmm_pe (
  input  logic                clk,
  input  logic                rst_n,
  spmm_nz_if.pe               nz,
  output spmm_pkg::col_idx_t  wgt_addr_o,
  input  spmm_pkg::data_t     wgt_data_i,
  output logic                sum_vld_o,
  output spmm_pkg::acc_t      sum_o,
  output spmm_pkg::num_node_t num_node_o,
  output logic                src_flag_o
);

  logic                vld_d;
  spmm_pkg::data_t     val_d;
  logic                first_d;
  logic                last_d;
  spmm_pkg::num_node_t num_node_d;
  logic                src_flag_d;
  spmm_pkg::acc_t      prod;
  spmm_pkg::acc_t      acc_nxt;
  spmm_pkg::acc_t      acc_q;

  // Weight lookup straight from the beat
  assign wgt_addr_o = nz.col_idx;

  // Beat delayed to line up with the returned weight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_d <= 1'b0;
    end else begin
      vld_d <= nz.vld;
    end
  end

  always_ff @(posedge clk) begin
    val_d      <= nz.val;
    first_d    <= nz.first;
    last_d     <= nz.last;
    num_node_d <= nz.num_node;
    src_flag_d <= nz.src_flag;
  end

  // Signed product sign extended to the accumulator width
  assign prod    = val_d * wgt_data_i;
  // A first beat restarts the sum
  assign acc_nxt = first_d ? prod : (acc_q + prod);

  always_ff @(posedge clk) begin
    if (vld_d) begin
      acc_q <= acc_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_vld_o <= 1'b0;
    end else begin
      sum_vld_o <= vld_d && last_d;
    end
  end

  // Header fields follow the closing beat of the row
  always_ff @(posedge clk) begin
    if (vld_d && last_d) begin
      num_node_o <= num_node_d;
      src_flag_o <= src_flag_d;
    end
  end

  assign sum_o = acc_q;

endmodule

`default_nettype wire

//--- hdl/spmm_pkg.sv
`default_nettype none

package spmm_pkg;

  // Datapath widths
  localparam int DATA_WIDTH     = 8;
  localparam int NUM_FEATURE_IN = 64;
  localparam int COL_IDX_WIDTH  = $clog2(NUM_FEATURE_IN);
  // One extra bit so a full row length still fits
  localparam int ROW_LEN_WIDTH  = COL_IDX_WIDTH + 1;
  localparam int NUM_NODE_WIDTH = 8;
  localparam int ACC_WIDTH      = 24;
  localparam int WH_DATA_WIDTH  = 12;
  localparam int ROW_IDX_WIDTH  = 14;

  // Saturation limits of the output word
  localparam int WH_MAX = (2 ** (WH_DATA_WIDTH - 1)) - 1;
  localparam int WH_MIN = -(2 ** (WH_DATA_WIDTH - 1));

  typedef logic signed [DATA_WIDTH-1:0] data_t;
  typedef logic [COL_IDX_WIDTH-1:0]     col_idx_t;
  typedef logic [ROW_LEN_WIDTH-1:0]     row_len_t;
  typedef logic [NUM_NODE_WIDTH-1:0]    num_node_t;
  typedef logic signed [ACC_WIDTH-1:0]  acc_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_t;
  typedef logic [ROW_IDX_WIDTH-1:0]     row_idx_t;

  // Row decoder states
  typedef enum logic [0:0] {
    IDLE = 1'b0,
    ROW  = 1'b1
  } decode_state_t;

endpackage

`default_nettype wire

//--- hdl/spmm_row_decode.sv
`timescale 1ns/100ps
`default_nettype none

module spmm_row_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                row_vld_i,
  input  spmm_pkg::row_len_t  row_len_i,
  input  spmm_pkg::num_node_t num_node_i,
  input  logic                src_flag_i,
  input  logic                nz_vld_i,
  input  spmm_pkg::col_idx_t  col_idx_i,
  input  spmm_pkg::data_t     val_i,
  output logic                pe_rdy_o,
  spmm_nz_if.decode           nz
);

  spmm_pkg::decode_state_t state_q;
  spmm_pkg::row_len_t      row_len_q;
  spmm_pkg::row_len_t      nz_cnt_q;
  spmm_pkg::num_node_t     num_node_q;
  logic                    src_flag_q;
  logic                    nz_take;
  logic                    nz_last;

  assign pe_rdy_o = (state_q == spmm_pkg::IDLE);
  assign nz_take  = (state_q == spmm_pkg::ROW) && nz_vld_i;
  // Final nonzero of the latched row
  assign nz_last  = ((nz_cnt_q + spmm_pkg::row_len_t'(1)) == row_len_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= spmm_pkg::IDLE;
      nz_cnt_q <= '0;
      nz.vld   <= 1'b0;
    end else begin
      nz.vld <= nz_take;
      case (state_q)
        spmm_pkg::IDLE: begin
          if (row_vld_i) begin
            state_q  <= spmm_pkg::ROW;
            nz_cnt_q <= '0;
          end
        end
        spmm_pkg::ROW: begin
          if (nz_vld_i) begin
            nz_cnt_q <= nz_cnt_q + spmm_pkg::row_len_t'(1);
            if (nz_last) begin
              state_q <= spmm_pkg::IDLE;
            end
          end
        end
        default: state_q <= spmm_pkg::IDLE;
      endcase
    end
  end

  // Header fields held for the whole row
  always_ff @(posedge clk) begin
    if (pe_rdy_o && row_vld_i) begin
      row_len_q  <= row_len_i;
      num_node_q <= num_node_i;
      src_flag_q <= src_flag_i;
    end
  end

  // Beat payload
  always_ff @(posedge clk) begin
    if (nz_take) begin
      nz.col_idx  <= col_idx_i;
      nz.val      <= val_i;
      nz.first    <= (nz_cnt_q == '0);
      nz.last     <= nz_last;
      nz.num_node <= num_node_q;
      nz.src_flag <= src_flag_q;
    end
  end

endmodule

`default_nettype wire

//--- hdl/spmm_row_result.sv
`timescale 1ns/100ps
`default_nettype none

module spmm_row_result (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sum_vld_i,
  input  spmm_pkg::acc_t      sum_i,
  input  spmm_pkg::num_node_t num_node_i,
  input  logic                src_flag_i,
  output logic                res_vld_o,
  output spmm_pkg::wh_t       res_o,
  output spmm_pkg::row_idx_t  row_idx_o,
  output spmm_pkg::num_node_t num_node_o,
  output logic                src_flag_o
);

  spmm_pkg::wh_t      sum_sat;
  spmm_pkg::row_idx_t row_cnt_q;

  // Clamp the wide sum into the output range
  always_comb begin
    if (sum_i > spmm_pkg::WH_MAX) begin
      sum_sat = spmm_pkg::wh_t'(spmm_pkg::WH_MAX);
    end else if (sum_i < spmm_pkg::WH_MIN) begin
      sum_sat = spmm_pkg::wh_t'(spmm_pkg::WH_MIN);
    end else begin
      sum_sat = spmm_pkg::wh_t'(sum_i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_vld_o  <= 1'b0;
      res_o      <= '0;
      row_idx_o  <= '0;
      num_node_o <= '0;
      src_flag_o <= 1'b0;
      row_cnt_q  <= '0;
    end else begin
      res_vld_o <= sum_vld_i;
      if (sum_vld_i) begin
        res_o      <= sum_sat;
        num_node_o <= num_node_i;
        src_flag_o <= src_flag_i;
        // Index is the number of rows finished before this one
        row_idx_o  <= row_cnt_q;
        row_cnt_q  <= row_cnt_q + spmm_pkg::row_idx_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/spmm_top.sv
`timescale 1ns/100ps
`default_nettype none

module spmm_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wgt_we_i,
  input  spmm_pkg::col_idx_t  wgt_addr_i,
  input  spmm_pkg::data_t     wgt_data_i,
  input  logic                row_vld_i,
  input  spmm_pkg::row_len_t  row_len_i,
  input  spmm_pkg::num_node_t num_node_i,
  input  logic                src_flag_i,
  input  logic                nz_vld_i,
  input  spmm_pkg::col_idx_t  col_idx_i,
  input  spmm_pkg::data_t     val_i,
  output logic                pe_rdy_o,
  output logic                res_vld_o,
  output spmm_pkg::wh_t       res_o,
  output spmm_pkg::row_idx_t  row_idx_o,
  output spmm_pkg::num_node_t num_node_o,
  output logic                src_flag_o
);

  spmm_pkg::col_idx_t  wgt_raddr;
  spmm_pkg::data_t     wgt_rdata;
  logic                sum_vld;
  spmm_pkg::acc_t      sum;
  spmm_pkg::num_node_t sum_num_node;
  logic                sum_src_flag;

  // Decoded nonzero beats
  spmm_nz_if nz ();

  spmm_row_decode spmm_row_decode_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .row_vld_i  (row_vld_i),
    .row_len_i  (row_len_i),
    .num_node_i (num_node_i),
    .src_flag_i (src_flag_i),
    .nz_vld_i   (nz_vld_i),
    .col_idx_i  (col_idx_i),
    .val_i      (val_i),
    .pe_rdy_o   (pe_rdy_o),
    .nz         (nz.decode)
  );

  spmm_weight_mem spmm_weight_mem_i (
    .clk     (clk),
    .we_i    (wgt_we_i),
    .waddr_i (wgt_addr_i),
    .wdata_i (wgt_data_i),
    .raddr_i (wgt_raddr),
    .rdata_o (wgt_rdata)
  );

  spmm_pe spmm_pe_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .nz         (nz.pe),
    .wgt_addr_o (wgt_raddr),
    .wgt_data_i (wgt_rdata),
    .sum_vld_o  (sum_vld),
    .sum_o      (sum),
    .num_node_o (sum_num_node),
    .src_flag_o (sum_src_flag)
  );

  spmm_row_result spmm_row_result_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .sum_vld_i  (sum_vld),
    .sum_i      (sum),
    .num_node_i (sum_num_node),
    .src_flag_i (sum_src_flag),
    .res_vld_o  (res_vld_o),
    .res_o      (res_o),
    .row_idx_o  (row_idx_o),
    .num_node_o (num_node_o),
    .src_flag_o (src_flag_o)
  );

endmodule

`default_nettype wire

//--- hdl/spmm_weight_mem.sv
`timescale 1ns/100ps
`default_nettype none

module spmm_weight_mem (
  input  logic               clk,
  input  logic               we_i,
  input  spmm_pkg::col_idx_t waddr_i,
  input  spmm_pkg::data_t    wdata_i,
  input  spmm_pkg::col_idx_t raddr_i,
  output spmm_pkg::data_t    rdata_o
);

  // One W column with one signed weight per input feature
  spmm_pkg::data_t mem [spmm_pkg::NUM_FEATURE_IN];

  // Host load port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Registered read so the weight returns one cycle after the address
  always_ff @(posedge clk) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

//--- tests/spmm_chk.sv
`timescale 1ns/100ps
`default_nettype none

// Protocol and reset checks on the top-level ports
module spmm_chk (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic pe_rdy_o,
  input wire logic res_vld_o,
  input wire logic row_vld_i,
  input wire logic nz_vld_i
);

  rdy_in_reset: assert property (@(posedge clk) !rst_n |-> pe_rdy_o)
    else $error("pe_rdy_o low during reset");

  no_res_in_reset: assert property (@(posedge clk) !rst_n |-> !res_vld_o)
    else $error("res_vld_o high during reset");

  // Nonzeros belong to an open row only
  nz_only_in_row: assert property (@(posedge clk) disable iff (!rst_n)
    nz_vld_i |-> !pe_rdy_o)
    else $error("nz_vld_i high while pe_rdy_o is high");

  hdr_only_when_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    row_vld_i |-> pe_rdy_o)
    else $error("row_vld_i high while pe_rdy_o is low");

endmodule

bind spmm_top spmm_chk spmm_chk_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .pe_rdy_o  (pe_rdy_o),
  .res_vld_o (res_vld_o),
  .row_vld_i (row_vld_i),
  .nz_vld_i  (nz_vld_i)
);

`default_nettype wire

//--- tests/spmm_tb.sv
`timescale 1ns/100ps
`default_nettype none

module spmm_tb;

  localparam int MAX_TESTS = 64;
  localparam int MAX_NZ    = 512;

  logic clk;
  logic rst_n;
  logic wgt_we_i;
  spmm_pkg::col_idx_t  wgt_addr_i;
  spmm_pkg::data_t     wgt_data_i;
  logic                row_vld_i;
  spmm_pkg::row_len_t  row_len_i;
  spmm_pkg::num_node_t num_node_i;
  logic                src_flag_i;
  logic                nz_vld_i;
  spmm_pkg::col_idx_t  col_idx_i;
  spmm_pkg::data_t     val_i;
  logic                pe_rdy_o;
  logic                res_vld_o;
  spmm_pkg::wh_t       res_o;
  spmm_pkg::row_idx_t  row_idx_o;
  spmm_pkg::num_node_t num_node_o;
  logic                src_flag_o;

  // Contents of the tests file
  int w_addr [MAX_TESTS];
  int w_val [MAX_TESTS];
  int num_wgt;
  logic [8*24-1:0] t_name [MAX_TESTS];
  int t_len [MAX_TESTS];
  int t_node [MAX_TESTS];
  int t_flag [MAX_TESTS];
  int t_exp [MAX_TESTS];
  int t_first_nz [MAX_TESTS];
  int t_nz_seen [MAX_TESTS];
  int num_tests;
  int nz_col [MAX_NZ];
  int nz_val [MAX_NZ];
  int num_nz;

  int exp_q[$];
  int last_q[$];
  int cycle_cnt;
  int cycle_limit;
  int err_cnt;
  int pass_cnt;
  int fail_cnt;
  int mon_idx;
  int mon_last;
  int mon_errs;

  spmm_top spmm_top_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Simulation timed out waiting for results after %0d cycles", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_value(input string test, input string what, input int exp,
                             input int act);
    if (exp != act) begin
      $display("Mismatch %s %s: expected %0d, actual %0d", test, what, exp, act);
      err_cnt++;
    end
  endtask

  // Result monitor for rows returning in the order they were sent
  always @(posedge clk) begin
    if (rst_n && res_vld_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected result: res_vld_o pulsed with no row pending");
        err_cnt++;
      end else begin
        mon_idx  = exp_q.pop_front();
        mon_last = last_q.pop_front();
        mon_errs = err_cnt;
        check_value($sformatf("%0s", t_name[mon_idx]), "res_o", t_exp[mon_idx], int'(res_o));
        check_value($sformatf("%0s", t_name[mon_idx]), "row_idx_o", mon_idx, int'(row_idx_o));
        check_value($sformatf("%0s", t_name[mon_idx]), "num_node_o", t_node[mon_idx],
                    int'(num_node_o));
        check_value($sformatf("%0s", t_name[mon_idx]), "src_flag_o", t_flag[mon_idx],
                    int'(src_flag_o));
        // Seen one edge after it rises
        check_value($sformatf("%0s", t_name[mon_idx]), "latency", 3,
                    cycle_cnt - mon_last - 1);
        if (err_cnt == mon_errs) begin
          $display("PASS %0s", t_name[mon_idx]);
          pass_cnt++;
        end else begin
          $display("FAIL %0s", t_name[mon_idx]);
          fail_cnt++;
        end
      end
    end
  end

  task automatic read_tests();
    int fd;
    string line;
    int a;
    int b;
    int c;
    int d;
    int e;
    logic [8*24-1:0] name;
    fd = $fopen("tests/spmm_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/spmm_tests.txt");
      err_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        case (line.getc(0))
          "W": begin
            void'($sscanf(line, "W %d %d", a, b));
            w_addr[num_wgt] = a;
            w_val[num_wgt]  = b;
            num_wgt++;
          end
          "T": begin
            void'($sscanf(line, "T %s %d %d %d %d", name, a, b, c, d));
            t_name[num_tests]     = name;
            t_len[num_tests]      = a;
            t_node[num_tests]     = b;
            t_flag[num_tests]     = c;
            t_exp[num_tests]      = d;
            t_first_nz[num_tests] = num_nz;
            num_tests++;
          end
          "N": begin
            void'($sscanf(line, "N %d %d", a, e));
            nz_col[num_nz] = a;
            nz_val[num_nz] = e;
            num_nz++;
            t_nz_seen[num_tests-1]++;
          end
          default: begin
            $display("Tests file has a line of unknown kind: %s", line);
            err_cnt++;
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  // Called right after an edge at which the decoder will be idle
  task automatic send_row(input int t);
    int gap;
    row_vld_i  <= 1'b1;
    row_len_i  <= spmm_pkg::row_len_t'(t_len[t]);
    num_node_i <= spmm_pkg::num_node_t'(t_node[t]);
    src_flag_i <= t_flag[t][0];
    for (int i = 0; i < t_len[t]; i++) begin
      gap = int'($urandom_range(2, 0));
      @(posedge clk);
      row_vld_i <= 1'b0;
      nz_vld_i  <= 1'b0;
      repeat (gap) @(posedge clk);
      nz_vld_i  <= 1'b1;
      col_idx_i <= spmm_pkg::col_idx_t'(nz_col[t_first_nz[t] + i]);
      val_i     <= spmm_pkg::data_t'(nz_val[t_first_nz[t] + i]);
    end
    // This edge samples the last nonzero
    @(posedge clk);
    nz_vld_i <= 1'b0;
    exp_q.push_back(t);
    last_q.push_back(cycle_cnt);
  endtask

  initial begin
    void'($urandom(36));
    clk = 1'b0;
    rst_n = 1'b0;
    wgt_we_i = 1'b0;
    wgt_addr_i = '0;
    wgt_data_i = '0;
    row_vld_i = 1'b0;
    row_len_i = '0;
    num_node_i = '0;
    src_flag_i = 1'b0;
    nz_vld_i = 1'b0;
    col_idx_i = '0;
    val_i = '0;
    cycle_cnt = 0;
    read_tests();
    cycle_limit = 16 + 2 * num_wgt + 3 * num_nz + 2 * num_tests + 60;
    if (num_tests == 0) begin
      $display("No test rows were read from the tests file");
      err_cnt++;
    end
    for (int t = 0; t < num_tests; t++) begin
      if (t_nz_seen[t] != t_len[t]) begin
        $display("Test %0s lists %0d nonzeros but its row length is %0d",
                 t_name[t], t_nz_seen[t], t_len[t]);
        err_cnt++;
      end
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    // No result may appear while idle after reset
    repeat (4) @(posedge clk);
    check_value("after_reset", "pe_rdy_o", 1, int'(pe_rdy_o));
    for (int i = 0; i < num_wgt; i++) begin
      wgt_we_i   <= 1'b1;
      wgt_addr_i <= spmm_pkg::col_idx_t'(w_addr[i]);
      wgt_data_i <= spmm_pkg::data_t'(w_val[i]);
      @(posedge clk);
    end
    wgt_we_i <= 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      send_row(t);
    end
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("Tests: %0d, passed: %0d, failed: %0d, errors: %0d",
             num_tests, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/spmm_tests.txt
# W addr weight | T name row_len num_node src_flag expected_result
# N col_idx value (the nonzeros of the T line above, in order)
W 0 5
W 3 -7
W 10 12
W 17 -1
W 25 100
W 31 -128
W 40 127
W 47 3
W 55 -50
W 63 64
T single_a0 1 10 1 15
N 0 3
T single_a63 1 20 0 -128
N 63 -2
T single_a31 1 5 1 128
N 31 -1
T single_a40 1 42 0 889
N 40 7
T mixed_signs 4 33 0 -39
N 3 4
N 10 -3
N 17 5
N 47 10
T repeat_col 3 7 1 400
N 25 2
N 25 -1
N 25 3
T sat_high 3 99 0 2047
N 40 127
N 63 100
N 25 50
T sat_low 2 1 1 -2048
N 31 127
N 55 100
T near_max 3 200 0 2045
N 25 20
N 47 15
N 0 0
T exact_min 1 255 1 -2048
N 31 16
T long_row 6 64 0 76
N 0 1
N 3 1
N 10 1
N 17 1
N 47 1
N 63 1
